/* serv_cfg.svh */
`ifndef SERV_CFG_SVH
`define SERV_CFG_SVH

// Address of the first fetch after reset
`define SERV_RESET_PC 32'h0000_0000

// General registers, x0 included
`define SERV_NREGS 32

`endif

/* serv_pkg.sv */
package serv_pkg;

   // Operand B source
   typedef enum logic {
      OP_B_RS2 = 1'b0,
      OP_B_IMM = 1'b1
   } op_b_src_t;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_t;

   // Write-back source
   typedef enum logic [1:0] {
      RD_ALU  = 2'd0,
      RD_IMM  = 2'd1,
      RD_LINK = 2'd2,
      RD_MEM  = 2'd3
   } rd_sel_t;

endpackage

/* serv_if.sv */
`timescale 1ns/1ps

interface serv_cnt_if;
   logic       cnt_en;
   logic [4:0] cnt;
   logic       init;
   logic       cnt_done;

   modport state (output cnt_en, cnt, init, cnt_done);
   modport user  (input cnt_en, cnt, init, cnt_done);
endinterface

interface serv_dec_if import serv_pkg::*; ();
   logic [4:0] rd_addr;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;
   logic       rd_en;
   op_b_src_t  op_b_src;
   alu_op_t    alu_op;
   rd_sel_t    rd_sel;
   logic       imm;
   logic       branch;
   logic       branch_ne;
   logic       jal;
   logic       mem_op;
   logic       mem_we;

   modport dec (output rd_addr, rs1_addr, rs2_addr, rd_en, op_b_src, alu_op, rd_sel,
                imm, branch, branch_ne, jal, mem_op, mem_we);
   modport user (input rd_addr, rs1_addr, rs2_addr, rd_en, op_b_src, alu_op, rd_sel,
                 imm, branch, branch_ne, jal, mem_op, mem_we);
endinterface

/* serv_state.sv */
`timescale 1ns/1ps

module serv_state (
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_ibus_ack,
   input  logic      i_dbus_ack,
   serv_dec_if.user  dec,
   serv_cnt_if.state cnt,
   output logic      o_ibus_cyc,
   output logic      o_dbus_cyc,
   output logic      o_load_run
);

   localparam logic [1:0] PH_FETCH = 2'd0;
   localparam logic [1:0] PH_RUN   = 2'd1;
   localparam logic [1:0] PH_DBUS  = 2'd2;
   localparam logic [1:0] PH_LOAD  = 2'd3;

   logic [1:0] phase;
   logic [4:0] bit_cnt;
   logic       running;
   logic       done;

   // Both the main run and the load write-back run clock the datapath
   assign running = (phase == PH_RUN) || (phase == PH_LOAD);
   assign done    = running && (bit_cnt == 5'd31);

   assign o_ibus_cyc = (phase == PH_FETCH);
   assign o_dbus_cyc = (phase == PH_DBUS);
   assign o_load_run = (phase == PH_LOAD);

   assign cnt.cnt_en   = running;
   assign cnt.cnt      = bit_cnt;
   assign cnt.init     = running && (bit_cnt == 5'd0);
   assign cnt.cnt_done = done;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase   <= PH_FETCH;
         bit_cnt <= 5'd0;
      end else begin
         // Wraps to zero after bit 31
         if (running)
            bit_cnt <= bit_cnt + 5'd1;
         case (phase)
            PH_FETCH: begin
               if (i_ibus_ack)
                  phase <= PH_RUN;
            end
            PH_RUN: begin
               if (done)
                  phase <= dec.mem_op ? PH_DBUS : PH_FETCH;
            end
            PH_DBUS: begin
               if (i_dbus_ack)
                  phase <= dec.mem_we ? PH_FETCH : PH_LOAD;
            end
            default: begin
               if (done)
                  phase <= PH_FETCH;
            end
         endcase
      end
   end

endmodule

/* serv_decode.sv */
`timescale 1ns/1ps

module serv_decode import serv_pkg::*; (
   input  logic        clk,
   input  logic        i_reset,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   serv_cnt_if.user    cnt,
   serv_dec_if.dec     dec
);

   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_OPIMM  = 5'b00100;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_OP     = 5'b01100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_JAL    = 5'b11011;

   logic [4:0]  opcode;
   logic [2:0]  funct3;
   logic        funct7_5;
   logic [31:0] imm_sr;
   logic [31:0] imm_word;
   logic [4:0]  new_opc;
   alu_op_t     alu_fn;

   assign new_opc = i_ibus_rdt[6:2];
   assign dec.imm = imm_sr[0];

   // Sign-extended immediate of the incoming word, by format
   always_comb begin
      case (new_opc)
         OPC_LUI:
            imm_word = {i_ibus_rdt[31:12], 12'd0};
         OPC_STORE:
            imm_word = {{21{i_ibus_rdt[31]}}, i_ibus_rdt[30:25], i_ibus_rdt[11:7]};
         OPC_BRANCH:
            imm_word = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[7], i_ibus_rdt[30:25],
                        i_ibus_rdt[11:8], 1'b0};
         OPC_JAL:
            imm_word = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                        i_ibus_rdt[30:21], 1'b0};
         default:
            imm_word = {{21{i_ibus_rdt[31]}}, i_ibus_rdt[30:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset)
         opcode <= OPC_OPIMM;
      else if (i_ibus_ack)
         opcode <= new_opc;
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         funct3       <= i_ibus_rdt[14:12];
         funct7_5     <= i_ibus_rdt[30];
         dec.rd_addr  <= i_ibus_rdt[11:7];
         dec.rs1_addr <= i_ibus_rdt[19:15];
         dec.rs2_addr <= i_ibus_rdt[24:20];
         imm_sr       <= imm_word;
      end else if (cnt.cnt_en) begin
         // Rotate so a second run sees the same immediate
         imm_sr <= {imm_sr[0], imm_sr[31:1]};
      end
   end

   always_comb begin
      case (funct3)
         3'b100:  alu_fn = ALU_XOR;
         3'b110:  alu_fn = ALU_OR;
         3'b111:  alu_fn = ALU_AND;
         default: alu_fn = ALU_ADD;
      endcase
   end

   always_comb begin
      dec.rd_en     = 1'b0;
      dec.op_b_src  = OP_B_IMM;
      dec.alu_op    = ALU_ADD;
      dec.rd_sel    = RD_ALU;
      dec.branch    = 1'b0;
      dec.branch_ne = funct3[0];
      dec.jal       = 1'b0;
      dec.mem_op    = 1'b0;
      dec.mem_we    = 1'b0;
      case (opcode)
         OPC_OP: begin
            dec.rd_en    = 1'b1;
            dec.op_b_src = OP_B_RS2;
            dec.alu_op   = (funct3 == 3'b000 && funct7_5) ? ALU_SUB : alu_fn;
         end
         OPC_OPIMM: begin
            dec.rd_en  = 1'b1;
            dec.alu_op = alu_fn;
         end
         OPC_LUI: begin
            dec.rd_en  = 1'b1;
            dec.rd_sel = RD_IMM;
         end
         OPC_LOAD: begin
            dec.rd_en  = 1'b1;
            dec.rd_sel = RD_MEM;
            dec.mem_op = 1'b1;
         end
         OPC_STORE: begin
            dec.mem_op = 1'b1;
            dec.mem_we = 1'b1;
         end
         OPC_BRANCH: begin
            dec.op_b_src = OP_B_RS2;
            dec.alu_op   = ALU_SUB;
            dec.branch   = 1'b1;
         end
         OPC_JAL: begin
            dec.rd_en  = 1'b1;
            dec.rd_sel = RD_LINK;
            dec.jal    = 1'b1;
         end
         default: begin
            dec.rd_en = 1'b0;
         end
      endcase
   end

endmodule

/* serv_alu.sv */
`timescale 1ns/1ps

module serv_alu import serv_pkg::*; (
   input  logic     clk,
   input  logic     i_reset,
   input  logic     i_rs1,
   input  logic     i_op_b,
   serv_cnt_if.user cnt,
   serv_dec_if.user dec,
   output logic     o_rd,
   output logic     o_eq
);

   logic sub;
   logic b_in;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic eq_in;
   logic eq_q;

   assign sub  = (dec.alu_op == ALU_SUB);
   assign b_in = i_op_b ^ sub;

   // Bit 0 takes the preset carry, 1 for subtract
   assign carry_in = cnt.init ? sub : carry_q;
   assign sum      = i_rs1 ^ b_in ^ carry_in;

   // Sticky compare, includes the current bit
   assign eq_in = cnt.init ? 1'b1 : eq_q;
   assign o_eq  = eq_in & ~(i_rs1 ^ i_op_b);

   always_comb begin
      case (dec.alu_op)
         ALU_AND: o_rd = i_rs1 & i_op_b;
         ALU_OR:  o_rd = i_rs1 | i_op_b;
         ALU_XOR: o_rd = i_rs1 ^ i_op_b;
         default: o_rd = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else if (cnt.cnt_en) begin
         carry_q <= (i_rs1 & b_in) | (carry_in & (i_rs1 ^ b_in));
         eq_q    <= o_eq;
      end
   end

endmodule

/* serv_ctrl.sv */
`timescale 1ns/1ps
`include "serv_cfg.svh"

module serv_ctrl (
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_eq,
   serv_cnt_if.user    cnt,
   serv_dec_if.user    dec,
   output logic        o_link,
   output logic [31:0] o_ibus_adr
);

   logic [31:0] pc;
   logic [30:0] pc4_sr;
   logic [30:0] pcimm_sr;
   logic        four_bit;
   logic        c4_in;
   logic        c4_q;
   logic        ci_in;
   logic        ci_q;
   logic        pc4_bit;
   logic        pcimm_bit;
   logic        take;
   logic        load_addr_run;
   logic        second_q;

   assign four_bit  = (cnt.cnt == 5'd2);
   assign c4_in     = cnt.init ? 1'b0 : c4_q;
   assign ci_in     = cnt.init ? 1'b0 : ci_q;
   assign pc4_bit   = pc[0] ^ four_bit ^ c4_in;
   assign pcimm_bit = pc[0] ^ dec.imm ^ ci_in;

   assign take = dec.jal | (dec.branch & (i_eq ^ dec.branch_ne));

   // First run of a load only forms the address
   assign load_addr_run = dec.mem_op & ~dec.mem_we & ~second_q;

   assign o_link     = pc4_bit;
   assign o_ibus_adr = pc;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc       <= `SERV_RESET_PC;
         c4_q     <= 1'b0;
         ci_q     <= 1'b0;
         second_q <= 1'b0;
      end else if (cnt.cnt_en) begin
         c4_q <= (pc[0] & four_bit) | (c4_in & (pc[0] ^ four_bit));
         ci_q <= (pc[0] & dec.imm) | (ci_in & (pc[0] ^ dec.imm));
         if (cnt.cnt_done) begin
            second_q <= load_addr_run;
            if (load_addr_run)
               pc <= {pc[0], pc[31:1]};
            else if (take)
               pc <= {pcimm_bit, pcimm_sr};
            else
               pc <= {pc4_bit, pc4_sr};
         end else begin
            pc <= {pc[0], pc[31:1]};
         end
      end
   end

   // Bits 0..30 of both candidates, top bit joins at cnt_done
   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         pc4_sr   <= {pc4_bit, pc4_sr[30:1]};
         pcimm_sr <= {pcimm_bit, pcimm_sr[30:1]};
      end
   end

endmodule

/* serv_rf.sv */
`timescale 1ns/1ps
`include "serv_cfg.svh"

module serv_rf (
   input  logic     clk,
   input  logic     i_reset,
   input  logic     i_rd,
   serv_cnt_if.user cnt,
   serv_dec_if.user dec,
   output logic     o_rs1,
   output logic     o_rs2
);

   logic [31:0]            regs [1:`SERV_NREGS-1];
   logic [`SERV_NREGS-1:0] lsbs;
   logic                   load_addr_run;
   logic                   second_q;
   logic                   wen;

   // No write while a load is still forming its address
   assign load_addr_run = dec.mem_op & ~dec.mem_we & ~second_q;
   assign wen = cnt.cnt_en & dec.rd_en & (dec.rd_addr != 5'd0) & ~load_addr_run;

   // x0 reads as zero
   always_comb begin
      lsbs[0] = 1'b0;
      for (int i = 1; i < `SERV_NREGS; i++)
         lsbs[i] = regs[i][0];
   end

   assign o_rs1 = lsbs[dec.rs1_addr];
   assign o_rs2 = lsbs[dec.rs2_addr];

   always_ff @(posedge clk) begin
      if (i_reset)
         second_q <= 1'b0;
      else if (cnt.cnt_done)
         second_q <= load_addr_run;
   end

   // Every register rotates once per bit, rd takes the new bit instead
   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         for (int i = 1; i < `SERV_NREGS; i++) begin
            if (wen && (dec.rd_addr == 5'(i)))
               regs[i] <= {i_rd, regs[i][31:1]};
            else
               regs[i] <= {regs[i][0], regs[i][31:1]};
         end
      end
   end

endmodule

/* serv_mem_if.sv */
`timescale 1ns/1ps

module serv_mem_if (
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_addr_bit,
   input  logic        i_rs2,
   input  logic [31:0] i_dbus_rdt,
   input  logic        i_dbus_ack,
   serv_cnt_if.user    cnt,
   serv_dec_if.user    dec,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic [3:0]  o_dbus_sel,
   output logic        o_dbus_we,
   output logic        o_rd
);

   logic [31:0] adr_sr;
   logic [31:0] dat_sr;
   logic [31:0] rdt_sr;
   logic        rdt_valid;

   assign o_dbus_adr = {adr_sr[31:2], 2'b00};
   assign o_dbus_dat = dat_sr;
   assign o_dbus_sel = 4'b1111;
   assign o_dbus_we  = dec.mem_we;
   assign o_rd       = rdt_valid & rdt_sr[0];

   // Address and store data, frozen during the load write-back run
   always_ff @(posedge clk) begin
      if (cnt.cnt_en && dec.mem_op && !rdt_valid) begin
         adr_sr <= {i_addr_bit, adr_sr[31:1]};
         dat_sr <= {i_rs2, dat_sr[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_dbus_ack && !dec.mem_we)
         rdt_sr <= i_dbus_rdt;
      else if (cnt.cnt_en)
         rdt_sr <= {1'b0, rdt_sr[31:1]};
   end

   always_ff @(posedge clk) begin
      if (i_reset)
         rdt_valid <= 1'b0;
      else if (i_dbus_ack && !dec.mem_we)
         rdt_valid <= 1'b1;
      else if (cnt.cnt_done)
         rdt_valid <= 1'b0;
   end

endmodule

/* serv_top.sv */
`timescale 1ns/1ps

module serv_top import serv_pkg::*; (
   input  logic        clk,
   input  logic        i_reset,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_dbus_rdt,
   input  logic        i_dbus_ack,
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic [3:0]  o_dbus_sel,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc
);

   logic load_run;
   logic rs1;
   logic rs2;
   logic op_b;
   logic alu_rd;
   logic alu_eq;
   logic link;
   logic mem_rd;
   logic rd;

   serv_cnt_if cnt_bus ();
   serv_dec_if dec_bus ();

   assign op_b = (dec_bus.op_b_src == OP_B_IMM) ? dec_bus.imm : rs2;

   // Write-back mux
   always_comb begin
      case (dec_bus.rd_sel)
         RD_IMM:  rd = dec_bus.imm;
         RD_LINK: rd = link;
         RD_MEM:  rd = load_run & mem_rd;
         default: rd = alu_rd;
      endcase
   end

   serv_state u_state (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .dec        (dec_bus),
      .cnt        (cnt_bus),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_load_run (load_run)
   );

   serv_decode u_decode (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (o_ibus_cyc & i_ibus_ack),
      .cnt        (cnt_bus),
      .dec        (dec_bus)
   );

   serv_alu u_alu (
      .clk     (clk),
      .i_reset (i_reset),
      .i_rs1   (rs1),
      .i_op_b  (op_b),
      .cnt     (cnt_bus),
      .dec     (dec_bus),
      .o_rd    (alu_rd),
      .o_eq    (alu_eq)
   );

   serv_ctrl u_ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_eq       (alu_eq),
      .cnt        (cnt_bus),
      .dec        (dec_bus),
      .o_link     (link),
      .o_ibus_adr (o_ibus_adr)
   );

   serv_rf u_rf (
      .clk     (clk),
      .i_reset (i_reset),
      .i_rd    (rd),
      .cnt     (cnt_bus),
      .dec     (dec_bus),
      .o_rs1   (rs1),
      .o_rs2   (rs2)
   );

   serv_mem_if u_mem_if (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_addr_bit (alu_rd),
      .i_rs2      (rs2),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (o_dbus_cyc & i_dbus_ack),
      .cnt        (cnt_bus),
      .dec        (dec_bus),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_rd       (mem_rd)
   );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic o_clk,
   output logic o_reset
);

   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;
   end

   // Two cycles of reset
   initial begin
      o_reset = 1'b1;
      repeat (2) @(posedge o_clk);
      o_reset <= 1'b0;
   end

endmodule

/* tb_serv_top.sv */
`timescale 1ns/1ps
`include "serv_cfg.svh"

module tb_serv_top;

   localparam int LIMIT = 400;
   localparam int NMAX  = 48;

   logic        clk;
   logic        rst;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] i_dbus_rdt;
   logic        i_dbus_ack;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic [3:0]  o_dbus_sel;
   logic        o_dbus_we;
   logic        o_dbus_cyc;

   integer      seed = 32'h66c15472;
   logic [31:0] imem [0:63];
   logic [31:0] dmem [0:15];
   logic [31:0] ref_mem [0:15];
   logic [31:0] ref_x [0:31];
   logic [31:0] tab_pc [0:NMAX-1];
   logic [31:0] tab_instr [0:NMAX-1];
   logic [31:0] next_pc;
   int          n_instr;
   logic        mem_expected;
   logic [1:0]  ibus_wait;
   logic [1:0]  dbus_wait;

   tb_clk_gen u_clk_gen (
      .o_clk   (clk),
      .o_reset (rst)
   );

   serv_top DUT (
      .clk        (clk),
      .i_reset    (rst),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc)
   );

   task automatic report_failure(input string msg);
      $display("Error at %0t: %s", $time, msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   // Instruction encoders
   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
      return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Adds a table row at the current PC and steps the PC by off
   task automatic push(input logic [31:0] instr, input logic [31:0] off);
      tab_pc[n_instr]    = next_pc;
      tab_instr[n_instr] = instr;
      imem[next_pc[7:2]] = instr;
      next_pc = next_pc + off;
      n_instr++;
   endtask

   // RV32I reference for register and memory effects
   task automatic ref_exec(input logic [31:0] w, input logic [31:0] pc,
                           output logic is_mem, output logic is_st,
                           output logic [31:0] adr, output logic [31:0] dat);
      logic [31:0] i_imm;
      logic [31:0] s_imm;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic        wr;
      i_imm  = {{20{w[31]}}, w[31:20]};
      s_imm  = {{20{w[31]}}, w[31:25], w[11:7]};
      a      = ref_x[w[19:15]];
      b      = ref_x[w[24:20]];
      is_mem = 1'b0;
      is_st  = 1'b0;
      adr    = 32'd0;
      dat    = 32'd0;
      res    = 32'd0;
      wr     = 1'b0;
      case (w[6:0])
         7'b0110011, 7'b0010011: begin
            if (w[6:0] == 7'b0010011)
               b = i_imm;
            case (w[14:12])
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               3'b111:  res = a & b;
               default: res = (w[5] && w[30]) ? a - b : a + b;
            endcase
            wr = 1'b1;
         end
         7'b0110111: begin
            res = {w[31:12], 12'd0};
            wr  = 1'b1;
         end
         7'b1101111: begin
            res = pc + 32'd4;
            wr  = 1'b1;
         end
         7'b0000011: begin
            is_mem = 1'b1;
            adr    = a + i_imm;
            res    = ref_mem[adr[5:2]];
            wr     = 1'b1;
         end
         7'b0100011: begin
            is_mem = 1'b1;
            is_st  = 1'b1;
            adr    = a + s_imm;
            dat    = b;
            ref_mem[adr[5:2]] = b;
         end
         default: wr = 1'b0;
      endcase
      if (wr && w[11:7] != 5'd0)
         ref_x[w[11:7]] = res;
   endtask

   task automatic wait_fetch();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > LIMIT)
            report_failure("timed out waiting for an instruction fetch");
      end while (!(o_ibus_cyc && i_ibus_ack));
   endtask

   task automatic wait_dbus();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > LIMIT)
            report_failure("timed out waiting for a data bus access");
      end while (!(o_dbus_cyc && i_dbus_ack));
   endtask

   // Instruction bus responder with random ack delay
   always @(posedge clk) begin
      if (rst) begin
         i_ibus_ack <= 1'b0;
         ibus_wait  <= 2'd0;
      end else if (i_ibus_ack) begin
         i_ibus_ack <= 1'b0;
      end else if (o_ibus_cyc) begin
         if (ibus_wait == 2'd0) begin
            i_ibus_ack <= 1'b1;
            i_ibus_rdt <= imem[o_ibus_adr[7:2]];
            ibus_wait  <= 2'($random(seed));
         end else begin
            ibus_wait <= ibus_wait - 2'd1;
         end
      end
   end

   // Data memory at 0x100..0x13c
   always @(posedge clk) begin
      if (rst) begin
         i_dbus_ack <= 1'b0;
         dbus_wait  <= 2'd0;
      end else if (i_dbus_ack) begin
         i_dbus_ack <= 1'b0;
      end else if (o_dbus_cyc) begin
         if (dbus_wait == 2'd0) begin
            i_dbus_ack <= 1'b1;
            i_dbus_rdt <= dmem[o_dbus_adr[5:2]];
            if (o_dbus_we)
               dmem[o_dbus_adr[5:2]] = o_dbus_dat;
            dbus_wait <= 2'($random(seed));
         end else begin
            dbus_wait <= dbus_wait - 2'd1;
         end
      end
   end

   always @(negedge clk) begin
      if (!rst && o_dbus_cyc && !mem_expected)
         report_failure("data bus cycle outside a load or store");
   end

   initial begin
      logic        is_mem;
      logic        is_st;
      logic [31:0] adr;
      logic [31:0] dat;
      i_ibus_rdt   <= 32'd0;
      i_ibus_ack   <= 1'b0;
      i_dbus_rdt   <= 32'd0;
      i_dbus_ack   <= 1'b0;
      mem_expected = 1'b0;
      n_instr      = 0;
      next_pc      = `SERV_RESET_PC;
      for (int i = 0; i < 64; i++)
         imem[i] = 32'h0000_0013;
      for (int i = 0; i < 16; i++) begin
         dmem[i]    = $random(seed);
         ref_mem[i] = dmem[i];
      end
      for (int i = 0; i < 32; i++)
         ref_x[i] = 32'd0;

      push(enc_i(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011), 4);
      push(enc_i(12'hFAA, 5'd0, 3'b000, 5'd2, 7'b0010011), 4);
      push(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 4);
      push(enc_s(12'h100, 5'd3), 4);
      push(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 4);
      push(enc_s(12'h104, 5'd3), 4);
      push(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 4);
      push(enc_s(12'h108, 5'd3), 4);
      push(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 4);
      push(enc_s(12'h10C, 5'd3), 4);
      push(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 4);
      push(enc_s(12'h110, 5'd3), 4);
      push(enc_i(12'h0F0, 5'd1, 3'b111, 5'd3, 7'b0010011), 4);
      push(enc_s(12'h114, 5'd3), 4);
      push(enc_i(12'h300, 5'd2, 3'b110, 5'd3, 7'b0010011), 4);
      push(enc_s(12'h118, 5'd3), 4);
      push(enc_i(12'hFFF, 5'd1, 3'b100, 5'd3, 7'b0010011), 4);
      push(enc_s(12'h11C, 5'd3), 4);
      push({20'hABCDE, 5'd6, 7'b0110111}, 4);
      push(enc_s(12'h120, 5'd6), 4);
      push(enc_i(12'h005, 5'd1, 3'b000, 5'd0, 7'b0010011), 4);
      push(enc_s(12'h124, 5'd0), 4);
      push(enc_i(12'h130, 5'd0, 3'b010, 5'd7, 7'b0000011), 4);
      push(enc_s(12'h128, 5'd7), 4);
      // Taken branches skip the filler slots
      push(enc_b(13'd8, 5'd1, 5'd1, 3'b000), 8);
      push(enc_b(13'd8, 5'd2, 5'd1, 3'b000), 4);
      push(enc_b(13'd12, 5'd2, 5'd1, 3'b001), 12);
      push(enc_b(13'd8, 5'd1, 5'd1, 3'b001), 4);
      push(enc_j(21'd16, 5'd9), 16);
      push(enc_s(12'h12C, 5'd9), 4);
      push(enc_j(21'd0, 5'd0), 0);

      for (int i = 0; i < n_instr; i++) begin
         wait_fetch();
         check_value("o_ibus_adr", o_ibus_adr, tab_pc[i]);
         @(negedge clk);
         check_value("o_ibus_cyc", {31'd0, o_ibus_cyc}, 32'd0);
         ref_exec(tab_instr[i], tab_pc[i], is_mem, is_st, adr, dat);
         if (is_mem) begin
            mem_expected = 1'b1;
            wait_dbus();
            check_value("o_dbus_adr", o_dbus_adr, adr);
            check_value("o_dbus_sel", {28'd0, o_dbus_sel}, 32'hF);
            check_value("o_dbus_we", {31'd0, o_dbus_we}, {31'd0, is_st});
            if (is_st)
               check_value("o_dbus_dat", o_dbus_dat, dat);
            @(posedge clk);
            mem_expected = 1'b0;
         end
      end
      // The final jump targets itself
      wait_fetch();
      check_value("o_ibus_adr", o_ibus_adr, next_pc);
      $display("Verification passed");
      $finish;
   end

endmodule

/* project.f */
+incdir+.
serv_pkg.sv
serv_if.sv
serv_state.sv
serv_decode.sv
serv_alu.sv
serv_ctrl.sv
serv_rf.sv
serv_mem_if.sv
serv_top.sv
tb_clk_gen.sv
tb_serv_top.sv

/* Makefile */
SIM = obj_dir/Vtb_serv_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f project.f --top-module tb_serv_top

run: compile
	./$(SIM) | tee run.log
	@grep -q "Verification passed" run.log

clean:
	rm -rf obj_dir run.log
